// File: sim/nnLayer_testdata.txt
# op addr data, hex: W write, E write expecting pslverr, R read expecting data
# S start and wait for done, F addr count data writes data to count words
F 400 78 00000000
F 200 1e 00000000
# Weights for inputs 0..2, word n*30+i
W 400 00000003
W 404 00000005
W 408 fffffffe
W 478 ffffffff
W 4f0 00020000
W 4f4 00010000
W 570 00072345
# Biases
W 100 00006000
W 104 00001000
W 108 00246000
W 10c 00abc000
# Activations, 0x2000 is 1.0
W 200 00002000
W 204 00004000
W 208 00001000
# Readback
R 404 00000005
R 408 fffffffe
R 570 00072345
R 10c 00abc000
R 208 00001000
R 004 00000000
S
R 004 00000002
R 300 0000000f
R 304 00000000
R 308 00000000
R 30c 00009700
# Unmapped, result write, then weight write and start while busy
E 008 00000005
E 300 00000001
W 000 00000001
R 004 00000001
E 404 00007777
E 000 00000001
S
R 404 00000005
R 300 0000000f
R 30c 00009700
# New activations, old weights
W 200 00006000
W 204 00008000
W 208 00002000
S
R 300 0000001e
R 304 00000000
R 308 00000123
R 30c 00000000
R 004 00000002

// File: list.f
verilog/nnPkg.sv
verilog/nnApbDecode.sv
verilog/nnParamStore.sv
verilog/nnMacExecute.sv
verilog/nnResult.sv
verilog/nnLayerTop.sv
sim/nnLayer_checker.sv
sim/nnLayerTb.sv

// File: run.sh
#!/bin/sh
# Build the layer engine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns --top-module nnLayerTb -f list.f
out=$(./obj_dir/VnnLayerTb 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

// File: sim/nnLayerTb.sv
`timescale 1ns/1ns
`default_nettype none

module nnLayerTb import nnPkg::*; ();

	localparam int NumInputs = 30;
	localparam int NumNodes = 4;
	localparam int RecordCycles = NumNodes * (NumInputs + 1) + 20; // One run plus APB slack

	logic clk = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addrWidth-1:0] paddr;
	logic [dataWidth-1:0] pwdata;
	logic [dataWidth-1:0] prdata;
	logic pready;
	logic pslverr;

	byte recOp[$];
	logic [dataWidth-1:0] recA[$];
	logic [dataWidth-1:0] recB[$];
	logic [dataWidth-1:0] recC[$];
	int cycles = 0;
	int cycleLimit = 0; // Set once the records are counted

	nnLayerTop u_nnLayerTop (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycleLimit != 0 && cycles >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles without finishing the records", cycles);
			failRun();
		end
	end

	task automatic failRun();
		$display("Checks failed");
		$fatal(1, "Stopped at the first failure");
	endtask

	// Bias, activation and weight pages are the registered store
	function automatic bit storeAddr(input logic [addrWidth-1:0] addr);
		return (addr >= biasBase && addr < resultBase) || addr >= weightBase;
	endfunction

	task automatic apbTransfer(input logic wr, input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] wdata, output logic [dataWidth-1:0] rdata,
		output logic err, output int accessCycles);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		accessCycles = 0;
		do
		begin
			@(negedge clk); // Mid-cycle, after the drive settles
			accessCycles++;
		end
		while (!pready);
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		repeat ($urandom % 4) @(posedge clk);
	endtask

	task automatic writeCheck(input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] data, input logic expectErr);
		logic [dataWidth-1:0] rdata;
		logic err;
		int acc;
		apbTransfer(1'b1, addr, data, rdata, err, acc);
		assert (err === expectErr && acc == 1)
		else
		begin
			$display("Error at %0t: write %h to %h gave pslverr %b after %0d cycles, expected %b",
				$time, data, addr, err, acc, expectErr);
			failRun();
		end
	endtask

	task automatic readCheck(input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] expected);
		logic [dataWidth-1:0] rdata;
		logic err;
		int acc;
		int expAcc;
		expAcc = storeAddr(addr) ? 2 : 1;
		apbTransfer(1'b0, addr, '0, rdata, err, acc);
		assert (err === 1'b0)
		else
		begin
			$display("Error at %0t: read of %h raised pslverr", $time, addr);
			failRun();
		end
		assert (rdata === expected && acc == expAcc)
		else
		begin
			$display("Error at %0t: read %h got %h in %0d cycles, expected %h in %0d",
				$time, addr, rdata, acc, expected, expAcc);
			failRun();
		end
	endtask

	task automatic readStatus(output logic [dataWidth-1:0] status);
		logic err;
		int acc;
		apbTransfer(1'b0, statusAddr, '0, status, err, acc);
		assert (err === 1'b0)
		else
		begin
			$display("Error at %0t: status read raised pslverr", $time);
			failRun();
		end
	endtask

	task automatic runToDone();
		logic [dataWidth-1:0] status;
		readStatus(status);
		while (status[0] === 1'b1) // Earlier run still going
			readStatus(status);
		writeCheck(ctrlAddr, 32'h1, 1'b0);
		readStatus(status);
		while (status[1] !== 1'b1)
			readStatus(status);
		assert (status[0] === 1'b0)
		else
		begin
			$display("Error at %0t: status %h shows busy together with done", $time, status);
			failRun();
		end
	endtask

	initial
	begin
		int fd;
		int total;
		string line;
		byte op;
		logic [dataWidth-1:0] a, b, c;
		logic [dataWidth-1:0] fillAddr;
		logic [dataWidth-1:0] fillData;
		void'($urandom(88));
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		fd = $fopen("sim/nnLayer_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test data file");
			failRun();
		end
		total = 0;
		while ($fgets(line, fd) > 0)
		begin
			op = (line.len() > 0) ? line[0] : 8'h0;
			if (op == "W" || op == "E" || op == "R" || op == "S" || op == "F")
			begin
				a = '0;
				b = '0;
				c = '0;
				void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
				recOp.push_back(op);
				recA.push_back(a);
				recB.push_back(b);
				recC.push_back(c);
				total += (op == "F") ? b : 1; // A fill costs one transfer per word
			end
		end
		$fclose(fd);
		cycleLimit = total * RecordCycles;

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		foreach (recOp[k])
		begin
			case (recOp[k])
				"W": writeCheck(recA[k][addrWidth-1:0], recB[k], 1'b0);
				"E": writeCheck(recA[k][addrWidth-1:0], recB[k], 1'b1);
				"R": readCheck(recA[k][addrWidth-1:0], recB[k]);
				"F":
					for (int j = 0; j < recB[k]; j++)
					begin
						fillAddr = recA[k] + 4 * j;
						// Whole byte address in the top bits, products of fill words wrap to zero
						fillData = recC[k] ^ (fillAddr << (dataWidth - addrWidth));
						writeCheck(fillAddr[addrWidth-1:0], fillData, 1'b0);
					end
				default: runToDone();
			endcase
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/nnLayer_checker.sv
`timescale 1ns/1ns
`default_nettype none

module nnLayerChecker import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic pwrite,
	input logic [addrWidth-1:0] paddr,
	input logic [dataWidth-1:0] pwdata,
	input logic pready,
	input logic start,
	input logic busy,
	input logic done
);

	// Request held from setup until the slave completes
	assert property (@(posedge clk) disable iff (reset)
		psel && !pready |=> psel && $stable({pwrite, paddr, pwdata}))
	else
		$error("APB request changed before pready");

	// Done comes up on the edge that drops busy
	assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> done)
	else
		$error("done not set when busy fell");

	assert property (@(posedge clk) disable iff (reset)
		!(busy && done))
	else
		$error("busy and done high together");

	assert property (@(posedge clk) disable iff (reset)
		start |=> busy)
	else
		$error("busy missing the cycle after start");

endmodule

bind nnLayerTop nnLayerChecker u_nnLayerChecker (
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.pwrite(pwrite),
	.paddr(paddr),
	.pwdata(pwdata),
	.pready(pready),
	.start(start),
	.busy(busy),
	.done(done)
);

`default_nettype wire

// File: verilog/nnLayerTop.sv
`timescale 1ns/1ns
`default_nettype none

module nnLayerTop import nnPkg::*; #(
	parameter int NumInputs = 30,
	parameter int NumNodes = 4
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [addrWidth-1:0] paddr,
	input logic [dataWidth-1:0] pwdata,
	output logic [dataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	apbReq_t apbReq;
	storeWrite_t storeWr;
	nodeSum_t nodeSum;
	storeKind_t hostRdKind;
	logic [wordWidth-1:0] hostRdIndex;
	logic [dataWidth-1:0] hostRdData;
	logic [nodeWidth-1:0] resultIndex;
	logic [outBits-1:0] resultData;
	logic start, busy, done;
	logic [nodeWidth-1:0] engNode;
	logic [wordWidth-1:0] engInput;
	logic [dataWidth-1:0] engWeight, engAct, engBias;

	assign apbReq = '{psel, penable, pwrite, paddr, pwdata};

	nnApbDecode #(.NumInputs(NumInputs), .NumNodes(NumNodes)) u_nnApbDecode (
		.clk, .reset, .apbReq, .prdata, .pready, .pslverr,
		.storeWr, .hostRdIndex, .hostRdKind, .hostRdData,
		.resultIndex, .resultData, .start, .busy, .done
	);

	nnParamStore #(.NumInputs(NumInputs), .NumNodes(NumNodes)) u_nnParamStore (
		.clk, .storeWr, .hostRdIndex, .hostRdKind, .hostRdData,
		.engNode, .engInput, .engWeight, .engAct, .engBias
	);

	nnMacExecute #(.NumInputs(NumInputs), .NumNodes(NumNodes)) u_nnMacExecute (
		.clk, .reset, .start, .engNode, .engInput,
		.engWeight, .engAct, .engBias, .nodeSum, .busy
	);

	nnResult #(.NumNodes(NumNodes)) u_nnResult (
		.clk, .reset, .start, .nodeSum, .resultIndex, .resultData, .done
	);

endmodule

`default_nettype wire

// File: verilog/nnResult.sv
`timescale 1ns/1ns
`default_nettype none

module nnResult import nnPkg::*; #(
	parameter int NumNodes = 4
) (
	input logic clk,
	input logic reset,
	input logic start,
	input nodeSum_t nodeSum,
	input logic [nodeWidth-1:0] resultIndex,
	output logic [outBits-1:0] resultData,
	output logic done
);

	localparam int NodeW = (NumNodes > 1) ? $clog2(NumNodes) : 1;

	logic [outBits-1:0] results [NumNodes];
	logic [outBits-1:0] quantized;
	logic lastNode;

	// Rectifier, negative sums clamp to zero, else take the fixed-point field
	assign quantized = nodeSum.sum[dataWidth-1] ? '0
		: nodeSum.sum[fracBits+outBits-1:fracBits];

	assign lastNode = nodeSum.node == nodeWidth'(NumNodes - 1);
	assign resultData = results[resultIndex[NodeW-1:0]];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < NumNodes; k++)
				results[k] <= '0;
			done <= 1'b0;
		end
		else
		begin
			if (nodeSum.valid)
				results[nodeSum.node[NodeW-1:0]] <= quantized;

			if (start)
				done <= 1'b0;
			else if (nodeSum.valid && lastNode)
				done <= 1'b1; // Same edge that drops busy
		end
	end

endmodule

`default_nettype wire

// File: verilog/nnMacExecute.sv
`timescale 1ns/1ns
`default_nettype none

module nnMacExecute import nnPkg::*; #(
	parameter int NumInputs = 30,
	parameter int NumNodes = 4
) (
	input logic clk,
	input logic reset,
	input logic start,
	output logic [nodeWidth-1:0] engNode,
	output logic [wordWidth-1:0] engInput,
	input logic [dataWidth-1:0] engWeight,
	input logic [dataWidth-1:0] engAct,
	input logic [dataWidth-1:0] engBias,
	output nodeSum_t nodeSum,
	output logic busy
);

	logic issuing; // Address stage active
	logic onBias; // Extra step per node that folds in the bias
	logic lastNode, lastInput, lastOut;
	logic bValid, bBias, bFirst; // Data stage, one cycle behind the address
	logic [nodeWidth-1:0] bNode;
	logic [dataWidth-1:0] acc;
	logic [dataWidth-1:0] product;

	assign lastNode = engNode == nodeWidth'(NumNodes - 1);
	assign lastInput = engInput == wordWidth'(NumInputs - 1);
	assign lastOut = nodeSum.valid && nodeSum.node == nodeWidth'(NumNodes - 1);

	assign product = engWeight * engAct; // Low 32 bits only

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issuing <= 1'b0;
			onBias <= 1'b0;
			busy <= 1'b0;
			bValid <= 1'b0;
			nodeSum.valid <= 1'b0;
			engNode <= '0;
			engInput <= '0;
		end
		else
		begin
			if (start)
			begin
				issuing <= 1'b1;
				onBias <= 1'b0;
				engNode <= '0;
				engInput <= '0;
			end
			else if (issuing)
			begin
				if (onBias)
				begin
					onBias <= 1'b0;
					engInput <= '0;
					if (lastNode)
					begin
						issuing <= 1'b0;
						engNode <= '0;
					end
					else
						engNode <= engNode + nodeWidth'(1);
				end
				else if (lastInput)
					onBias <= 1'b1; // Hold input index, stays in range
				else
					engInput <= engInput + wordWidth'(1);
			end

			if (start)
				busy <= 1'b1;
			else if (lastOut)
				busy <= 1'b0;

			bValid <= issuing;
			nodeSum.valid <= bValid & bBias;
		end

		bBias <= onBias;
		bFirst <= engInput == '0 && !onBias;
		bNode <= engNode;

		if (bValid)
		begin
			if (bBias)
			begin
				nodeSum.node <= bNode;
				nodeSum.sum <= acc + engBias; // Wraps mod 2^32
			end
			else
				acc <= (bFirst ? '0 : acc) + product;
		end
	end

endmodule

`default_nettype wire

// File: verilog/nnParamStore.sv
`timescale 1ns/1ns
`default_nettype none

module nnParamStore import nnPkg::*; #(
	parameter int NumInputs = 30,
	parameter int NumNodes = 4
) (
	input logic clk,
	input storeWrite_t storeWr,
	input logic [wordWidth-1:0] hostRdIndex,
	input storeKind_t hostRdKind,
	output logic [dataWidth-1:0] hostRdData,
	input logic [nodeWidth-1:0] engNode,
	input logic [wordWidth-1:0] engInput,
	output logic [dataWidth-1:0] engWeight,
	output logic [dataWidth-1:0] engAct,
	output logic [dataWidth-1:0] engBias
);

	localparam int NumWeights = NumNodes * NumInputs;
	localparam int NodeW = (NumNodes > 1) ? $clog2(NumNodes) : 1;
	localparam int InW = (NumInputs > 1) ? $clog2(NumInputs) : 1;
	localparam int WeightW = (NumWeights > 1) ? $clog2(NumWeights) : 1;

	logic [dataWidth-1:0] weights [NumWeights];
	logic [dataWidth-1:0] biases [NumNodes];
	logic [dataWidth-1:0] acts [NumInputs];
	logic [WeightW-1:0] engWeightIdx;

	assign engWeightIdx = WeightW'(int'(engNode) * NumInputs + int'(engInput)); // Row-major n,i

	always_ff @(posedge clk)
	begin
		if (storeWr.valid)
		begin
			if (storeWr.kind == kindWeight)
				weights[storeWr.index[WeightW-1:0]] <= storeWr.data;
			else if (storeWr.kind == kindBias)
				biases[storeWr.index[NodeW-1:0]] <= storeWr.data;
			else if (storeWr.kind == kindAct)
				acts[storeWr.index[InW-1:0]] <= storeWr.data;
		end

		case (hostRdKind)
			kindWeight: hostRdData <= weights[hostRdIndex[WeightW-1:0]];
			kindBias: hostRdData <= biases[hostRdIndex[NodeW-1:0]];
			kindAct: hostRdData <= acts[hostRdIndex[InW-1:0]];
			default: hostRdData <= '0;
		endcase

		// Engine port, new address every cycle
		engWeight <= weights[engWeightIdx];
		engAct <= acts[engInput[InW-1:0]];
		engBias <= biases[engNode[NodeW-1:0]];
	end

endmodule

`default_nettype wire

// File: verilog/nnApbDecode.sv
`timescale 1ns/1ns
`default_nettype none

module nnApbDecode import nnPkg::*; #(
	parameter int NumInputs = 30,
	parameter int NumNodes = 4
) (
	input logic clk,
	input logic reset,
	input apbReq_t apbReq,
	output logic [dataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output storeWrite_t storeWr,
	output logic [wordWidth-1:0] hostRdIndex,
	output storeKind_t hostRdKind,
	input logic [dataWidth-1:0] hostRdData,
	output logic [nodeWidth-1:0] resultIndex,
	input logic [outBits-1:0] resultData,
	output logic start,
	input logic busy,
	input logic done
);

	typedef enum logic {rdIdle, rdWait} rdState_t;

	rdState_t rdState;
	logic access, aligned, storeRead, protocolErr;
	logic isCtrl, isStatus, isBias, isAct, isResult, isWeight, isStore, mapped;
	logic [wordWidth-1:0] biasIdx, actIdx, resultIdx, weightIdx, storeIdx;
	storeKind_t storeKind;

	function automatic logic [wordWidth-1:0] regionIndex(input logic [addrWidth-1:0] addr,
		input logic [addrWidth-1:0] base);
		logic [addrWidth-1:0] offset;
		offset = addr - base;
		return offset[addrWidth-1:2];
	endfunction

	assign access = apbReq.psel & apbReq.penable;
	assign aligned = apbReq.paddr[1:0] == 2'b00;

	assign biasIdx = regionIndex(apbReq.paddr, biasBase);
	assign actIdx = regionIndex(apbReq.paddr, actBase);
	assign resultIdx = regionIndex(apbReq.paddr, resultBase);
	assign weightIdx = regionIndex(apbReq.paddr, weightBase);

	assign isCtrl = apbReq.paddr == ctrlAddr;
	assign isStatus = apbReq.paddr == statusAddr;
	assign isBias = aligned && apbReq.paddr[addrWidth-1:regionLsb] == biasBase[addrWidth-1:regionLsb]
		&& biasIdx < wordWidth'(NumNodes);
	assign isAct = aligned && apbReq.paddr[addrWidth-1:regionLsb] == actBase[addrWidth-1:regionLsb]
		&& actIdx < wordWidth'(NumInputs);
	assign isResult = aligned
		&& apbReq.paddr[addrWidth-1:regionLsb] == resultBase[addrWidth-1:regionLsb]
		&& resultIdx < wordWidth'(NumNodes);
	assign isWeight = aligned && apbReq.paddr >= weightBase
		&& weightIdx < wordWidth'(NumNodes * NumInputs);
	assign isStore = isBias | isAct | isWeight;
	assign mapped = isCtrl | isStatus | isStore | isResult;

	always_comb
	begin
		storeKind = kindWeight;
		storeIdx = weightIdx;
		if (isBias)
		begin
			storeKind = kindBias;
			storeIdx = biasIdx;
		end
		else if (isAct)
		begin
			storeKind = kindAct;
			storeIdx = actIdx;
		end
	end

	// Store reads take one extra access cycle for the registered read
	assign storeRead = access & ~apbReq.pwrite & isStore;
	assign pready = access & (~storeRead | rdState == rdWait);

	// Status and result are read-only, store and ctrl locked while running
	assign protocolErr = ~mapped | (apbReq.pwrite & (isResult | isStatus))
		| (apbReq.pwrite & busy & (isStore | isCtrl));
	assign pslverr = pready & protocolErr;

	always_ff @(posedge clk)
	begin
		if (reset)
			rdState <= rdIdle;
		else if (storeRead)
			rdState <= (rdState == rdIdle) ? rdWait : rdIdle;
	end

	assign storeWr.valid = access & apbReq.pwrite & isStore & ~busy;
	assign storeWr.kind = storeKind;
	assign storeWr.index = storeIdx;
	assign storeWr.data = apbReq.pwdata;

	assign hostRdIndex = storeIdx;
	assign hostRdKind = storeKind;
	assign resultIndex = resultIdx[nodeWidth-1:0];

	assign start = access & apbReq.pwrite & isCtrl & ~busy & apbReq.pwdata[0];

	always_comb
	begin
		prdata = '0;
		if (isStatus)
			prdata = {{(dataWidth-2){1'b0}}, done, busy};
		else if (isResult)
			prdata = {{(dataWidth-outBits){1'b0}}, resultData};
		else if (isStore)
			prdata = hostRdData;
	end

endmodule

`default_nettype wire

// File: verilog/nnPkg.sv
`default_nettype none

package nnPkg;

	localparam int dataWidth = 32;
	localparam int fracBits = 13;
	localparam int outBits = 16;
	localparam int addrWidth = 12;
	localparam int wordWidth = addrWidth - 2; // Word index inside a region
	localparam int nodeWidth = 7;
	localparam int regionLsb = 8; // Bias, act and result pages are 256 bytes

	localparam logic [addrWidth-1:0] ctrlAddr = 'h000;
	localparam logic [addrWidth-1:0] statusAddr = 'h004;
	localparam logic [addrWidth-1:0] biasBase = 'h100;
	localparam logic [addrWidth-1:0] actBase = 'h200;
	localparam logic [addrWidth-1:0] resultBase = 'h300;
	localparam logic [addrWidth-1:0] weightBase = 'h400;

	typedef enum logic [1:0] {kindWeight, kindBias, kindAct} storeKind_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [addrWidth-1:0] paddr;
		logic [dataWidth-1:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic valid;
		storeKind_t kind;
		logic [wordWidth-1:0] index;
		logic [dataWidth-1:0] data;
	} storeWrite_t;

	typedef struct packed {
		logic valid;
		logic [nodeWidth-1:0] node;
		logic [dataWidth-1:0] sum; // Wrapped, bias included
	} nodeSum_t;

endpackage

`default_nettype wire
